/* include/tb_programs.svh */
// test program images
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

function automatic logic [31:0] r_type(input funct_t fn, input logic [4:0] rd,
                                       input logic [4:0] rs, input logic [4:0] rt);
    return {SPECIAL, rs, rt, rd, 5'd0, fn};
endfunction

function automatic logic [31:0] i_type(input opcode_t op, input logic [4:0] rt,
                                       input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

// unused words read as nop
task automatic clear_rom();
    foreach (rom[a])
        rom[a] = 32'h0;
endtask

task automatic load_alu_program();
    clear_rom();
    rom[0]  = i_type(LUI,   5'd1, 5'd0, 16'h2000);  // peripheral base
    rom[1]  = i_type(ADDIU, 5'd2, 5'd0, 16'h1234);
    rom[2]  = i_type(ADDIU, 5'd3, 5'd2, 16'hfffb);  // -5
    rom[3]  = r_type(ADDU,  5'd4, 5'd2, 5'd3);
    rom[4]  = r_type(SUBU,  5'd5, 5'd3, 5'd4);
    rom[5]  = r_type(OR,    5'd6, 5'd4, 5'd1);
    rom[6]  = r_type(AND,   5'd7, 5'd6, 5'd5);
    rom[7]  = r_type(SLT,   5'd8, 5'd5, 5'd4);
    rom[8]  = i_type(SW,    5'd8, 5'd1, 16'h0000);  // store data forwarded
    rom[9]  = i_type(SW,    5'd7, 5'd1, 16'h0004);
    rom[10] = i_type(SW,    5'd6, 5'd1, 16'h0008);
    rom[11] = i_type(SW,    5'd3, 5'd1, 16'h000c);
    rom[12] = i_type(BEQ,   5'd0, 5'd0, 16'hffff);
endtask

task automatic load_scratch_program();
    clear_rom();
    rom[0] = i_type(LUI,   5'd1, 5'd0, 16'h2000);
    rom[1] = i_type(ADDIU, 5'd2, 5'd0, 16'h0040);  // scratch pointer
    rom[2] = i_type(ADDIU, 5'd3, 5'd0, 16'h7abc);
    rom[3] = i_type(SW,    5'd3, 5'd2, 16'h0008);
    rom[4] = i_type(LW,    5'd4, 5'd2, 16'h0008);
    rom[5] = r_type(ADDU,  5'd5, 5'd4, 5'd2);  // load-use
    rom[6] = i_type(SW,    5'd5, 5'd1, 16'h0000);
    rom[7] = i_type(BEQ,   5'd0, 5'd0, 16'hffff);
endtask

task automatic load_branch_program();
    clear_rom();
    rom[0] = i_type(LUI,   5'd1, 5'd0, 16'h2000);
    rom[1] = i_type(ADDIU, 5'd2, 5'd0, 16'h0005);
    rom[2] = i_type(ADDIU, 5'd3, 5'd0, 16'h0005);
    rom[3] = i_type(BEQ,   5'd3, 5'd2, 16'h0002);  // taken, to rom[6]
    rom[4] = i_type(SW,    5'd2, 5'd1, 16'h0000);  // skipped
    rom[5] = i_type(SW,    5'd2, 5'd1, 16'h0004);  // skipped
    rom[6] = i_type(SW,    5'd3, 5'd1, 16'h0008);
    rom[7] = i_type(BEQ,   5'd1, 5'd2, 16'h0001);  // not taken
    rom[8] = i_type(SW,    5'd2, 5'd1, 16'h000c);
    rom[9] = i_type(BEQ,   5'd0, 5'd0, 16'hffff);
endtask

task automatic load_periph_program();
    clear_rom();
    rom[0] = i_type(LUI,   5'd1, 5'd0, 16'h2000);
    rom[1] = i_type(LW,    5'd2, 5'd1, 16'h0100);
    rom[2] = i_type(LW,    5'd3, 5'd1, 16'h0104);
    rom[3] = r_type(ADDU,  5'd4, 5'd2, 5'd3);
    rom[4] = i_type(LW,    5'd5, 5'd1, 16'h0208);
    rom[5] = r_type(ADDU,  5'd4, 5'd4, 5'd5);
    rom[6] = i_type(SW,    5'd4, 5'd1, 16'h0000);
    rom[7] = i_type(SW,    5'd3, 5'd1, 16'h0004);
    rom[8] = i_type(BEQ,   5'd0, 5'd0, 16'hffff);
endtask

`endif

/* dv/core_tb.sv */
// core testbench
`timescale 1ns/1ns

module core_tb import structures::*; ();

    localparam int          CLK_PERIOD = 10;
    localparam int          NUM_TESTS  = 4;
    localparam logic [31:0] BASE       = 32'h2000_0000;
    localparam logic [31:0] LOAD_MASK  = 32'h5a5a_0000;  // peripheral read pattern

    logic        clock = 1'b0;
    logic        rst_n;
    logic [31:0] i_addr;
    logic [31:0] i_data;
    logic [31:0] d_addr;
    logic [31:0] d_wdata;
    logic [31:0] d_rdata;
    logic        d_we;
    logic        d_valid;
    logic        d_ready;

    logic [31:0] rom [256];
    logic [31:0] lfsr      = 32'hff73_1d2d;
    logic [1:0]  wait_left = 2'd0;
    logic        in_xfer   = 1'b0;
    logic [31:0] held_addr;
    logic [31:0] held_wdata;
    int          load_count;
    logic [31:0] store_addr_q [$];
    logic [31:0] store_data_q [$];
    logic [31:0] exp_addr_q [$];
    logic [31:0] exp_data_q [$];

    core #(.PERIPHERAL_BASE(BASE), .SCRATCH_WORDS(64)) u_dut (.*);

    // combinational instruction port
    assign i_data = $isunknown(i_addr) ? 32'h0 : rom[i_addr[9:2]];

    always #(CLK_PERIOD / 2) clock = ~clock;

    `include "tb_programs.svh"

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("FAIL: see errors above");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
    endtask

    // 4 cycles low with pc and data port checked throughout
    task automatic reset_core();
        store_addr_q.delete();
        store_data_q.delete();
        exp_addr_q.delete();
        exp_data_q.delete();
        load_count = 0;
        rst_n = 1'b0;
        repeat (4) begin
            @(negedge clock);
            check_value("i_addr", i_addr, 32'd0);
            check_value("d_valid", d_valid, 32'd0);
        end
        rst_n = 1'b1;
        @(negedge clock);
        check_value("i_addr", i_addr, 32'd4);  // first free edge steps pc from 0
        check_value("d_valid", d_valid, 32'd0);
    endtask

    task automatic check_run(input int n_loads);
        while (store_addr_q.size() < exp_addr_q.size())
            @(negedge clock);
        repeat (20) @(negedge clock);  // room for any stray store
        check_value("store count", store_addr_q.size(), exp_addr_q.size());
        check_value("peripheral load count", load_count, n_loads);
        foreach (exp_addr_q[k]) begin
            check_value("d_addr", store_addr_q[k], exp_addr_q[k]);
            check_value("d_wdata", store_data_q[k], exp_data_q[k]);
        end
    endtask

    // peripheral with 0 to 3 wait cycles per access
    always @(negedge clock) begin
        if (!rst_n) begin
            d_ready = 1'b0;
            in_xfer = 1'b0;
        end else if (d_valid) begin
            if (!in_xfer) begin
                in_xfer    = 1'b1;
                held_addr  = d_addr;
                held_wdata = d_wdata;
                lfsr         = lfsr_next(lfsr);
                wait_left[0] = lfsr[0];
                lfsr         = lfsr_next(lfsr);
                wait_left[1] = lfsr[0];
            end else begin
                check_value("d_addr", d_addr, held_addr);  // must hold while waiting
                check_value("d_wdata", d_wdata, held_wdata);
            end
            if (wait_left == 2'd0) begin
                d_ready = 1'b1;
                d_rdata = d_addr ^ LOAD_MASK;
                in_xfer = 1'b0;
                if (d_we) begin
                    store_addr_q.push_back(d_addr);
                    store_data_q.push_back(d_wdata);
                end else begin
                    load_count++;
                end
            end else begin
                d_ready   = 1'b0;
                wait_left = wait_left - 2'd1;
            end
        end else begin
            d_ready = 1'b0;
        end
    end

    task automatic test_alu();
        logic [31:0] r2, r3, r4, r5, r6, r7;
        load_alu_program();
        reset_core();
        r2 = 32'h0000_1234;
        r3 = r2 - 32'd5;
        r4 = r2 + r3;
        r5 = r3 - r4;
        r6 = r4 | BASE;
        r7 = r6 & r5;
        expect_store(BASE, {31'b0, $signed(r5) < $signed(r4)});
        expect_store(BASE + 32'd4, r7);
        expect_store(BASE + 32'd8, r6);
        expect_store(BASE + 32'd12, r3);
        check_run(0);
    endtask

    task automatic test_scratch();
        load_scratch_program();
        reset_core();
        expect_store(BASE, 32'h0000_7abc + 32'h0000_0040);
        check_run(0);  // scratch traffic stays off the port
    endtask

    task automatic test_branches();
        load_branch_program();
        reset_core();
        expect_store(BASE + 32'd8, 32'd5);
        expect_store(BASE + 32'd12, 32'd5);
        check_run(0);
    endtask

    task automatic test_periph_loads();
        logic [31:0] sum;
        load_periph_program();
        reset_core();
        sum = ((BASE + 32'h0100) ^ LOAD_MASK) + ((BASE + 32'h0104) ^ LOAD_MASK)
              + ((BASE + 32'h0208) ^ LOAD_MASK);
        expect_store(BASE, sum);
        expect_store(BASE + 32'd4, (BASE + 32'h0104) ^ LOAD_MASK);
        check_run(3);
    endtask

    initial begin
        rst_n   = 1'b0;
        d_ready = 1'b0;
        d_rdata = 32'h0;
        test_alu();
        test_scratch();
        test_branches();
        test_periph_loads();
        $display("PASS: all tests");
        $finish;
    end

    initial begin
        #(NUM_TESTS * 2000 * CLK_PERIOD);
        $display("timeout: the core did not finish its tests in time");
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

endmodule

/* list.f */
+incdir+include
logic/structures.sv
logic/core_fetch.sv
logic/core_decode.sv
logic/core_execute.sv
logic/core_memory.sv
logic/core.sv
dv/core_tb.sv

/* logic/core.sv */
// pipelined core top level
`timescale 1ns/1ns

module core import structures::*; #(
    parameter logic [XLEN-1:0] PERIPHERAL_BASE = 32'h2000_0000,
    parameter int              SCRATCH_WORDS   = 64
) (
    input  logic        clock,
    input  logic        rst_n,

    // instruction port, combinational
    output logic [31:0] i_addr,
    input  logic [31:0] i_data,

    // peripheral data port
    output logic [31:0] d_addr,
    output logic [31:0] d_wdata,
    input  logic [31:0] d_rdata,
    output logic        d_we,
    output logic        d_valid,
    input  logic        d_ready
);
    IF_regs_t    IF_regs;
    ID_regs_t    ID_regs;
    EX_regs_t    EX_regs;
    MEM_regs_t   MEM_regs;
    logic        load_stall;
    logic        mem_busy;
    logic        branch_taken;
    logic [31:0] branch_target;

    core_fetch u_fetch (
        .clock         (clock),
        .rst_n         (rst_n),
        .load_stall    (load_stall),
        .mem_busy      (mem_busy),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .i_data        (i_data),
        .i_addr        (i_addr),
        .IF_regs       (IF_regs)
    );

    core_decode u_decode (
        .clock           (clock),
        .rst_n           (rst_n),
        .IF_regs         (IF_regs),
        .EX_load_pending (ID_regs.valid & ID_regs.mem_read),  // load now in execute
        .EX_W_regnum     (ID_regs.W_regnum),
        .mem_busy        (mem_busy),
        .flush           (branch_taken),
        .MEM_regs        (MEM_regs),
        .ID_regs         (ID_regs),
        .load_stall      (load_stall)
    );

    core_execute u_execute (
        .clock         (clock),
        .rst_n         (rst_n),
        .ID_regs       (ID_regs),
        .mem_busy      (mem_busy),
        .MEM_regs      (MEM_regs),
        .EX_regs       (EX_regs),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    core_memory #(
        .PERIPHERAL_BASE (PERIPHERAL_BASE),
        .SCRATCH_WORDS   (SCRATCH_WORDS)
    ) u_memory (
        .clock    (clock),
        .rst_n    (rst_n),
        .EX_regs  (EX_regs),
        .d_rdata  (d_rdata),
        .d_ready  (d_ready),
        .d_addr   (d_addr),
        .d_wdata  (d_wdata),
        .d_we     (d_we),
        .d_valid  (d_valid),
        .mem_busy (mem_busy),
        .MEM_regs (MEM_regs)
    );

endmodule

/* logic/core_decode.sv */
// instruction decode and register file
`timescale 1ns/1ns

module core_decode import structures::*; (
    input  logic      clock,
    input  logic      rst_n,
    input  IF_regs_t  IF_regs,
    input  logic      EX_load_pending,  // load sitting in execute
    input  logic [4:0] EX_W_regnum,
    input  logic      mem_busy,
    input  logic      flush,
    input  MEM_regs_t MEM_regs,
    output ID_regs_t  ID_regs,
    output logic      load_stall
);
    logic [XLEN-1:0] rf [32];
    inst_t           inst;
    ID_regs_t        id_next;

    assign inst = IF_regs.inst;

    // register 0 reads zero, a same-cycle write wins
    function automatic logic [XLEN-1:0] read_reg(input logic [4:0] r,
                                                 input logic [XLEN-1:0] stored,
                                                 input MEM_regs_t wb);
        if (r == 5'd0)
            return '0;
        if (wb.write_enable && wb.W_regnum == r)
            return wb.W_data;
        return stored;
    endfunction

    always_ff @(posedge clock) begin
        if (MEM_regs.write_enable && MEM_regs.W_regnum != 5'd0 && !mem_busy)
            rf[MEM_regs.W_regnum] <= MEM_regs.W_data;
    end

    // consumer right behind a load waits one cycle
    assign load_stall = IF_regs.valid && EX_load_pending && EX_W_regnum != 5'd0 &&
                        (EX_W_regnum == inst.r.rs || EX_W_regnum == inst.r.rt);

    always_comb begin
        id_next              = '0;
        id_next.valid        = IF_regs.valid && !flush && !load_stall;  // else a bubble
        id_next.pc4          = IF_regs.pc4;
        id_next.A_data       = read_reg(inst.r.rs, rf[inst.r.rs], MEM_regs);
        id_next.B_data       = read_reg(inst.r.rt, rf[inst.r.rt], MEM_regs);
        id_next.imm          = {{(XLEN-16){inst.i.imm[15]}}, inst.i.imm};
        id_next.rs           = inst.r.rs;
        id_next.rt           = inst.r.rt;
        id_next.alu_op       = ALU_ADD;
        case (inst.r.opcode)
            SPECIAL: begin
                id_next.W_regnum     = inst.r.rd;
                id_next.write_enable = 1'b1;
                case (inst.r.funct)
                    ADDU:    id_next.alu_op = ALU_ADD;
                    SUBU:    id_next.alu_op = ALU_SUB;
                    AND:     id_next.alu_op = ALU_AND;
                    OR:      id_next.alu_op = ALU_OR;
                    SLT:     id_next.alu_op = ALU_SLT;
                    default: id_next.write_enable = 1'b0;  // unsupported funct is a nop
                endcase
            end
            ADDIU: begin
                id_next.W_regnum     = inst.i.rt;
                id_next.write_enable = 1'b1;
                id_next.use_imm      = 1'b1;
            end
            LUI: begin
                id_next.W_regnum     = inst.i.rt;
                id_next.write_enable = 1'b1;
                id_next.use_imm      = 1'b1;
                id_next.alu_op       = ALU_LUI;
            end
            LW: begin
                id_next.W_regnum     = inst.i.rt;
                id_next.write_enable = 1'b1;
                id_next.use_imm      = 1'b1;
                id_next.mem_read     = 1'b1;
            end
            SW: begin
                id_next.use_imm   = 1'b1;
                id_next.mem_write = 1'b1;
            end
            BEQ: begin
                id_next.is_branch = 1'b1;
                id_next.alu_op    = ALU_SUB;
            end
            default: ;  // anything else passes as a nop
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n)
            ID_regs.valid <= 1'b0;
        else if (!mem_busy)
            ID_regs <= id_next;
    end

endmodule

/* logic/core_execute.sv */
// execute stage with forwarding and branch resolve
`timescale 1ns/1ns

module core_execute import structures::*; (
    input  logic         clock,
    input  logic         rst_n,
    input  ID_regs_t     ID_regs,
    input  logic         mem_busy,
    input  MEM_regs_t    MEM_regs,
    output EX_regs_t     EX_regs,
    output logic         branch_taken,
    output logic [31:0]  branch_target
);
    forward_type_t   fwd_a;
    forward_type_t   fwd_b;
    logic            ex_fwd_ok;
    logic            mem_fwd_ok;
    logic [XLEN-1:0] a_val;
    logic [XLEN-1:0] b_val;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_out;
    EX_regs_t        ex_next;

    // nearest producer first
    function automatic forward_type_t fwd_sel(input logic [4:0] src,
                                              input logic       ex_ok,
                                              input logic [4:0] ex_dst,
                                              input logic       mem_ok,
                                              input logic [4:0] mem_dst);
        if (src == 5'd0)
            return FWD_NONE;
        if (ex_ok && ex_dst == src)
            return FWD_EX;
        if (mem_ok && mem_dst == src)
            return FWD_MEM;
        return FWD_NONE;
    endfunction

    function automatic logic [XLEN-1:0] fwd_mux(input forward_type_t sel,
                                                input logic [XLEN-1:0] reg_val,
                                                input logic [XLEN-1:0] ex_val,
                                                input logic [XLEN-1:0] mem_val);
        case (sel)
            FWD_EX:  return ex_val;
            FWD_MEM: return mem_val;
            default: return reg_val;
        endcase
    endfunction

    // load data is not ready in EX_regs, the hazard stall covers that case
    assign ex_fwd_ok  = EX_regs.valid && EX_regs.write_enable && !EX_regs.mem_read;
    assign mem_fwd_ok = MEM_regs.write_enable;

    always_comb begin
        fwd_a = fwd_sel(ID_regs.rs, ex_fwd_ok, EX_regs.W_regnum, mem_fwd_ok, MEM_regs.W_regnum);
        fwd_b = fwd_sel(ID_regs.rt, ex_fwd_ok, EX_regs.W_regnum, mem_fwd_ok, MEM_regs.W_regnum);
        a_val = fwd_mux(fwd_a, ID_regs.A_data, EX_regs.out, MEM_regs.W_data);
        b_val = fwd_mux(fwd_b, ID_regs.B_data, EX_regs.out, MEM_regs.W_data);
    end

    assign alu_b = ID_regs.use_imm ? ID_regs.imm : b_val;

    always_comb begin
        case (ID_regs.alu_op)
            ALU_SUB: alu_out = a_val - alu_b;
            ALU_AND: alu_out = a_val & alu_b;
            ALU_OR:  alu_out = a_val | alu_b;
            ALU_SLT: alu_out = {{(XLEN-1){1'b0}}, $signed(a_val) < $signed(alu_b)};
            ALU_LUI: alu_out = {alu_b[15:0], 16'h0000};
            default: alu_out = a_val + alu_b;  // add, also address calc
        endcase
    end

    // beq compares the forwarded registers, not the alu output
    assign branch_taken  = ID_regs.valid && ID_regs.is_branch && (a_val == b_val);
    assign branch_target = ID_regs.pc4 + {ID_regs.imm[XLEN-3:0], 2'b00};

    always_comb begin
        ex_next              = '0;
        ex_next.valid        = ID_regs.valid;
        ex_next.out          = alu_out;
        ex_next.B_data       = b_val;  // store data
        ex_next.W_regnum     = ID_regs.W_regnum;
        ex_next.write_enable = ID_regs.write_enable;
        ex_next.mem_read     = ID_regs.mem_read;
        ex_next.mem_write    = ID_regs.mem_write;
    end

    always_ff @(posedge clock) begin
        if (!rst_n)
            EX_regs.valid <= 1'b0;
        else if (!mem_busy)
            EX_regs <= ex_next;
    end

endmodule

/* logic/core_fetch.sv */
// instruction fetch stage
`timescale 1ns/1ns

module core_fetch import structures::*; (
    input  logic        clock,
    input  logic        rst_n,
    input  logic        load_stall,
    input  logic        mem_busy,
    input  logic        branch_taken,
    input  logic [31:0] branch_target,
    input  inst_t       i_data,
    output logic [31:0] i_addr,
    output IF_regs_t    IF_regs
);
    logic [31:0] pc;
    logic [31:0] pc4;

    assign pc4    = pc + 32'd4;
    assign i_addr = pc;  // instruction port answers in the same cycle

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pc            <= 32'd0;
            IF_regs.valid <= 1'b0;
        end else if (!mem_busy) begin  // peripheral wait freezes everything
            if (branch_taken) begin
                // redirect, drop the wrong-path fetch
                pc            <= branch_target;
                IF_regs.valid <= 1'b0;
            end else if (!load_stall) begin
                pc            <= pc4;
                IF_regs.valid <= 1'b1;
                IF_regs.pc4   <= pc4;
                IF_regs.inst  <= i_data;
            end
        end
    end

endmodule

/* logic/core_memory.sv */
// memory access and write-back
`timescale 1ns/1ns

module core_memory import structures::*; #(
    parameter logic [XLEN-1:0] PERIPHERAL_BASE = 32'h2000_0000,
    parameter int              SCRATCH_WORDS   = 64
) (
    input  logic         clock,
    input  logic         rst_n,
    input  EX_regs_t     EX_regs,
    input  logic [31:0]  d_rdata,
    input  logic         d_ready,
    output logic [31:0]  d_addr,
    output logic [31:0]  d_wdata,
    output logic         d_we,
    output logic         d_valid,
    output logic         mem_busy,
    output MEM_regs_t    MEM_regs
);
    localparam int IDX_BITS = $clog2(SCRATCH_WORDS);

    logic [XLEN-1:0]     scratch [SCRATCH_WORDS];
    logic [IDX_BITS-1:0] scratch_idx;
    logic [XLEN-1:0]     scratch_rdata;
    logic                is_periph;
    logic                mem_access;
    logic [XLEN-1:0]     load_data;
    logic [XLEN-1:0]     wb_data;

    assign is_periph   = EX_regs.out >= PERIPHERAL_BASE;
    assign mem_access  = EX_regs.valid && (EX_regs.mem_read || EX_regs.mem_write);
    assign scratch_idx = EX_regs.out[IDX_BITS+1:2];  // word index

    // scratch RAM, read in the same cycle
    assign scratch_rdata = scratch[scratch_idx];

    always_ff @(posedge clock) begin
        if (mem_access && EX_regs.mem_write && !is_periph)
            scratch[scratch_idx] <= EX_regs.B_data;
    end

    // peripheral port, driven straight from EX_regs so it stays put while held
    assign d_valid  = mem_access && is_periph;
    assign d_addr   = EX_regs.out;
    assign d_wdata  = EX_regs.B_data;
    assign d_we     = EX_regs.mem_write;
    assign mem_busy = d_valid && !d_ready;  // pipeline freezes until ready

    assign load_data = is_periph ? d_rdata : scratch_rdata;
    assign wb_data   = EX_regs.mem_read ? load_data : EX_regs.out;

    // captured as the instruction leaves, so d_rdata is taken on the ready cycle
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            MEM_regs.write_enable <= 1'b0;
        end else if (!mem_busy) begin
            MEM_regs.W_data       <= wb_data;
            MEM_regs.W_regnum     <= EX_regs.W_regnum;
            MEM_regs.write_enable <= EX_regs.valid && EX_regs.write_enable;
        end
    end

endmodule

/* logic/structures.sv */
// shared core types
package structures;

    localparam int XLEN = 32;  // data and register width

    typedef enum logic [5:0] {
        SPECIAL = 6'h00,  // r-type, decoded by funct
        BEQ     = 6'h04,
        ADDIU   = 6'h09,
        LUI     = 6'h0f,
        LW      = 6'h23,
        SW      = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        ADDU = 6'h21,
        SUBU = 6'h23,
        AND  = 6'h24,
        OR   = 6'h25,
        SLT  = 6'h2a
    } funct_t;

    typedef struct packed {
        opcode_t    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;  // unused by this core
        funct_t     funct;
    } r_fields_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fields_t;

    // one instruction word, two views
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } inst_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } alu_op_t;

    // where an execute operand comes from
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_EX,
        FWD_MEM
    } forward_type_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc4;
        inst_t           inst;
    } IF_regs_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc4;
        logic [XLEN-1:0] A_data;
        logic [XLEN-1:0] B_data;
        logic [XLEN-1:0] imm;  // sign extended
        logic [4:0]      rs;
        logic [4:0]      rt;
        logic [4:0]      W_regnum;
        logic            write_enable;
        alu_op_t         alu_op;
        logic            use_imm;
        logic            mem_read;
        logic            mem_write;
        logic            is_branch;
    } ID_regs_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] out;  // alu result or data address
        logic [XLEN-1:0] B_data;
        logic [4:0]      W_regnum;
        logic            write_enable;
        logic            mem_read;
        logic            mem_write;
    } EX_regs_t;

    // write-back values, kept one cycle for forwarding
    typedef struct packed {
        logic [XLEN-1:0] W_data;
        logic [4:0]      W_regnum;
        logic            write_enable;
    } MEM_regs_t;

endpackage
